// ==== all.f ====
+incdir+verilog
verilog/clock_face_pkg.sv
verilog/vga_timing.sv
verilog/hand_angle.sv
verilog/hand_raster.sv
verilog/face_composer.sv
verilog/clock_face_top.sv
tb/tb_clock.sv
tb/clock_face_asserts.sv
tb/tb_clock_face.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the clock face testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f all.f \
  --top-module tb_clock_face --Mdir obj_dir -o sim_clock_face
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

out=$(./obj_dir/sim_clock_face 2>&1)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if echo "$out" | grep -qxF "PASS: all tests"; then
  exit 0
fi
exit 1

// ==== tb/clock_face_asserts.sv ====
// sync width, period and blanking checks on the top level ports
// position is rebuilt from the output syncs, valid after the first hsync and vsync
`include "clock_face_settings.svh"

module clock_face_asserts (
  input logic                 vgaclk,
  input logic                 rst_n,
  input logic                 hsync,
  input logic                 vsync,
  input logic                 sync_b,
  input clock_face_pkg::rgb_t rgb
);
  timeunit 1ns;
  timeprecision 1ps;

  int unsigned h_low, h_per, v_low, v_per;  // run lengths in cycles
  int unsigned hpos, vpos;                  // position of the previous sample
  int unsigned cur_h, cur_v;                // position of this sample
  int unsigned fail_cnt;                    // read by the testbench
  logic        hsync_q, vsync_q;
  logic        seen_h, seen_v;              // tracker locked
  logic        h_fall, v_fall, h_rise, v_rise;
  logic        vis;

  always_comb
  begin
    h_fall = hsync_q && !hsync;
    v_fall = vsync_q && !vsync;
    h_rise = !hsync_q && hsync;
    v_rise = !vsync_q && vsync;
    cur_h  = h_fall ? `H_SYNC_START : ((hpos == `H_TOTAL - 1) ? 0 : hpos + 1);
    if (v_fall)
      cur_v = `V_SYNC_START;  // vsync falls on hcnt 0
    else if (cur_h == 0)
      cur_v = (vpos == `V_TOTAL - 1) ? 0 : vpos + 1;
    else
      cur_v = vpos;
    vis = (cur_h >= `H_VIS_START) && (cur_h < `H_VIS_START + `H_VIS) &&
          (cur_v >= `V_VIS_START) && (cur_v < `V_VIS_START + `V_VIS);
  end

  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hsync_q <= 1'b1;
      vsync_q <= 1'b1;
      {h_low, h_per, v_low, v_per} <= '0;
      {hpos, vpos} <= '0;
      {seen_h, seen_v} <= 2'b00;
    end
    else
    begin
      hsync_q <= hsync;
      vsync_q <= vsync;
      h_low   <= hsync ? 0 : h_low + 1;
      v_low   <= vsync ? 0 : v_low + 1;
      h_per   <= h_fall ? 1 : h_per + 1;  // cycles since last fall
      v_per   <= v_fall ? 1 : v_per + 1;
      hpos    <= cur_h;
      vpos    <= cur_v;
      if (h_fall) seen_h <= 1'b1;
      if (v_fall) seen_v <= 1'b1;
    end
  end

  initial fail_cnt = 0;

  a_hsync_width: assert property (@(posedge vgaclk) disable iff (!rst_n)
    h_rise |-> h_low == (`H_SYNC_END - `H_SYNC_START))
    else begin fail_cnt++; $error("hsync low for %0d cycles", h_low); end

  a_hsync_period: assert property (@(posedge vgaclk) disable iff (!rst_n)
    (seen_h && h_fall) |-> h_per == `H_TOTAL)
    else begin fail_cnt++; $error("hsync period %0d cycles", h_per); end

  a_vsync_width: assert property (@(posedge vgaclk) disable iff (!rst_n)
    v_rise |-> v_low == (`V_SYNC_END - `V_SYNC_START) * `H_TOTAL)
    else begin fail_cnt++; $error("vsync low for %0d cycles", v_low); end

  a_vsync_period: assert property (@(posedge vgaclk) disable iff (!rst_n)
    (seen_v && v_fall) |-> v_per == `V_TOTAL * `H_TOTAL)
    else begin fail_cnt++; $error("vsync period %0d cycles", v_per); end

  a_sync_b: assert property (@(posedge vgaclk) disable iff (!rst_n)
    sync_b == (hsync | vsync))
    else begin fail_cnt++; $error("sync_b does not match hsync and vsync"); end

  // black during sync and anywhere outside the window
  a_sync_blank: assert property (@(posedge vgaclk) disable iff (!rst_n)
    (!hsync || !vsync) |-> rgb == '0)
    else begin fail_cnt++; $error("rgb not black during sync"); end

  a_window_blank: assert property (@(posedge vgaclk) disable iff (!rst_n)
    (seen_h && seen_v && !vis) |-> rgb == '0)
    else begin fail_cnt++; $error("rgb not black at %0d,%0d", cur_h, cur_v); end

endmodule

bind clock_face_top clock_face_asserts i_clock_face_asserts (
  .vgaclk (vgaclk),
  .rst_n  (rst_n),
  .hsync  (hsync),
  .vsync  (vsync),
  .sync_b (sync_b),
  .rgb    (rgb)
);

// ==== tb/tb_clock.sv ====
// free running vgaclk, 10 ns period
// rst_n is held low for the first 4 rising edges, then released on an edge
module tb_clock (
  output logic vgaclk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial
  begin
    vgaclk = 1'b0;
    forever #5 vgaclk = ~vgaclk;
  end

  initial
  begin
    rst_n = 1'b0;
    repeat (4) @(posedge vgaclk);
    rst_n <= 1'b1;  // released on the 4th edge
  end

endmodule

// ==== tb/tb_clock_face.sv ====
// testbench top that drives now and probes single pixels of the output raster
// raster position is rebuilt from the output syncs on the falling edge
// each time is held two frames before probing
// all probes of one time fall within one frame
`include "clock_face_settings.svh"

module tb_clock_face;
  timeunit 1ns;
  timeprecision 1ps;
  import clock_face_pkg::*;

  localparam int LIMIT = 12 * `H_TOTAL * `V_TOTAL;  // 12 frames

  logic        vgaclk, rst_n;
  clock_time_t now;
  logic        hsync, vsync, sync_b;
  rgb_t        rgb;

  int          hpos, vpos;     // rebuilt counter of the sample on the output
  int          frames;         // vsync falls seen
  logic        hsync_q, vsync_q;
  logic        locked;
  event        sample_ev;      // tracker has taken the current sample
  int          cycles;
  int          errors;
  int          tests, tests_failed;
  integer      seed;

  tb_clock i_tb_clock (
    .vgaclk (vgaclk),
    .rst_n  (rst_n)
  );

  clock_face_top i_clock_face_top (
    .vgaclk (vgaclk),
    .rst_n  (rst_n),
    .now    (now),
    .hsync  (hsync),
    .vsync  (vsync),
    .sync_b (sync_b),
    .rgb    (rgb)
  );

  // raster tracker runs on the falling edge where outputs are stable
  initial
  begin
    hpos    = 0;
    vpos    = 0;
    frames  = 0;
    hsync_q = 1'b1;
    vsync_q = 1'b1;
    locked  = 1'b0;
  end

  always @(negedge vgaclk)
  begin
    if (hsync_q && !hsync)
      hpos = `H_SYNC_START;
    else
      hpos = (hpos == `H_TOTAL - 1) ? 0 : hpos + 1;
    if (vsync_q && !vsync)
    begin
      vpos   = `V_SYNC_START;
      hpos   = 0;            // vsync falls with hcnt 0
      frames = frames + 1;
      locked = 1'b1;
    end
    else if (hpos == 0)
      vpos = (vpos == `V_TOTAL - 1) ? 0 : vpos + 1;
    hsync_q = hsync;
    vsync_q = vsync;
    -> sample_ev;            // probes read hpos and vpos only after this
  end

  // run limit
  initial cycles = 0;

  always @(posedge vgaclk)
  begin
    cycles = cycles + 1;
    if (cycles >= LIMIT)
    begin
      $display("timeout, the run did not end within %0d cycles", LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  function automatic clock_time_t make_time(input int h, input int m, input int s);
    clock_time_t t;
    t.hour   = 5'(h);
    t.minute = 6'(m);
    t.second = 6'(s);
    return t;
  endfunction

  task automatic apply_time(input clock_time_t t);
    int start;
    @(posedge vgaclk);
    now <= t;
    start = frames;
    while (frames < start + 2)  // two vsync falls so the new time is surely sampled
      @(sample_ev);
  endtask

  // waits for the visible pixel x,y and compares its colour
  task automatic check_pixel(input string name, input int x, input int y,
                             input rgb_t expected, inout int fails);
    do
      @(sample_ev);
    while (!(locked && hpos == x + `H_VIS_START && vpos == y + `V_VIS_START));
    assert (rgb === expected)
    else
    begin
      $display("Fail %s at (%0d,%0d): expected %06h, actual %06h",
               name, x, y, expected, rgb);
      fails++;
    end
  endtask

  // face points lie inside the dial, above the centre and off every hand
  task automatic pick_face_point(output int x, output int y);
    int idx;
    idx = $unsigned($random(seed)) % 4;
    case (idx)
      0: begin x = 400; y = 120; end
      1: begin x = 250; y = 150; end
      2: begin x = 200; y = 200; end
      default: begin x = 430; y = 180; end
    endcase
  endtask

  // probes in raster order so one frame is enough
  task automatic run_time_test(input string name, input clock_time_t t,
                               input int hx, input int hy, input rgb_t hand_rgb);
    int fails;
    int fx, fy;
    fails = 0;
    apply_time(t);
    pick_face_point(fx, fy);
    check_pixel({name, " background"}, 10, 10, '0, fails);
    check_pixel({name, " face"}, fx, fy, `FACE_RGB, fails);
    check_pixel({name, " hand"}, hx, hy, hand_rgb, fails);
    tests++;
    if (fails != 0)
      tests_failed++;
    errors += fails;
    $display("test %s: %s", name, (fails == 0) ? "ok" : "failed");
  endtask

  initial
  begin
    int assert_fails;
    seed         = 30;
    errors       = 0;
    tests        = 0;
    tests_failed = 0;
    now          <= '0;
    @(posedge rst_n);
    run_time_test("second_15", make_time(0, 0, 15), 400, 240, `SECOND_RGB);
    run_time_test("minute_15", make_time(0, 15, 45), 450, 240, `MINUTE_RGB);
    run_time_test("hour_3", make_time(3, 0, 45), 400, 240, `HOUR_RGB);
    assert_fails = i_clock_face_top.i_clock_face_asserts.fail_cnt;
    $display("tests %0d, failed %0d, pixel errors %0d, assertion failures %0d",
             tests, tests_failed, errors, assert_fails);
    if (errors == 0 && assert_fails == 0)
      $display("PASS: all tests");
    else
      $display("FAIL: see errors above");
    $finish;
  end

endmodule

// ==== verilog/clock_face_pkg.sv ====
// shared types for the clock face
// hand geometry is the unrotated rectangle, hand drawn along +x from its corner
// tick is a hand angle in 6 degree steps, only 0 to 59 are meaningful
package clock_face_pkg;

  typedef logic [9:0]          coord_t;  // counter or screen coordinate
  typedef logic [5:0]          tick_t;   // 0..59
  typedef logic signed [17:0]  trig_t;   // sin/cos scaled by 2^16
  typedef logic [23:0]         rgb_t;    // r in the top byte

  typedef struct packed {
    logic [4:0] hour;    // 0..23
    logic [5:0] minute;
    logic [5:0] second;
  } clock_time_t;

  // relative to the visible origin, wraps outside the visible area
  typedef struct packed {
    coord_t x;
    coord_t y;
  } pixel_pos_t;

  typedef struct packed {
    logic hsync;    // active low
    logic vsync;    // active low
    logic visible;  // active high
  } sync_t;

  typedef struct packed {
    coord_t x;      // corner before rotation
    coord_t y;
    coord_t len;    // extent along x
    coord_t wid;    // extent along y
  } hand_geom_t;

  typedef enum logic [1:0] {HAND_SECOND, HAND_MINUTE, HAND_HOUR} hand_id_t;

  // thin long second hand, short fat hour hand
  localparam hand_geom_t hand_geoms [3] = '{
    '{x: 10'd270, y: 10'd238, len: 10'd200, wid: 10'd4},
    '{x: 10'd280, y: 10'd237, len: 10'd200, wid: 10'd6},
    '{x: 10'd280, y: 10'd236, len: 10'd150, wid: 10'd8}
  };

endpackage

// ==== verilog/clock_face_settings.svh ====
// raster timing for 640x480 inside an 800x525 frame, one pixel per vgaclk
// sync windows are half-open, end value excluded
// dial and hand geometry assume the dial centre stays at 320,240
`ifndef CLOCK_FACE_SETTINGS_SVH
`define CLOCK_FACE_SETTINGS_SVH

// horizontal, in vgaclk cycles
`define H_TOTAL       800
`define H_SYNC_START  8
`define H_SYNC_END    104   // first cycle after hsync
`define H_VIS_START   152
`define H_VIS         640

// vertical, in lines
`define V_TOTAL       525
`define V_SYNC_START  2
`define V_SYNC_END    4     // first line after vsync
`define V_VIS_START   37
`define V_VIS         480

// dial, in visible pixel coordinates
`define DIAL_X        320
`define DIAL_Y        240
`define DIAL_R        200

// colours as 8:8:8 rgb
`define FACE_RGB      24'hFF_FFFF
`define SECOND_RGB    24'hFF_0000
`define MINUTE_RGB    24'h00_00FF
`define HOUR_RGB      24'h00_FF00

// sine/cosine scale is 2^TRIG_FRAC
`define TRIG_FRAC     16

`endif

// ==== verilog/clock_face_top.sv ====
// analog clock face on a 640x480 raster, vgaclk is the pixel clock
// now is a plain level, sampled at the start of each vsync
// syncs and rgb leave two cycles after the internal counters, aligned
module clock_face_top (
  input  logic                        vgaclk,
  input  logic                        rst_n,
  input  clock_face_pkg::clock_time_t now,
  output logic                        hsync,
  output logic                        vsync,
  output logic                        sync_b,
  output clock_face_pkg::rgb_t        rgb
);
  import clock_face_pkg::*;

  pixel_pos_t pos;        // current raster position
  sync_t      sync;       // undelayed sync and visible
  tick_t      ticks [3];  // per hand, held for the frame
  logic [2:0] hits;       // registered, one cycle behind pos

  vga_timing i_vga_timing (
    .vgaclk (vgaclk),
    .rst_n  (rst_n),
    .pos    (pos),
    .sync   (sync)
  );

  hand_angle i_hand_angle (
    .vgaclk (vgaclk),
    .rst_n  (rst_n),
    .now    (now),
    .sync   (sync),
    .ticks  (ticks)
  );

  // one rasterizer per hand, geometry from the package table
  for (genvar i = HAND_SECOND; i <= HAND_HOUR; i++)
  begin : g_hand
    hand_raster #(.geom(hand_geoms[i])) i_hand_raster (
      .vgaclk (vgaclk),
      .rst_n  (rst_n),
      .pos    (pos),
      .tick   (ticks[i]),
      .hit    (hits[i])
    );
  end

  face_composer i_face_composer (
    .vgaclk (vgaclk),
    .rst_n  (rst_n),
    .pos    (pos),
    .sync   (sync),
    .hits   (hits),
    .hsync  (hsync),
    .vsync  (vsync),
    .sync_b (sync_b),
    .rgb    (rgb)
  );

endmodule

// ==== verilog/face_composer.sv ====
// lays the hands over the dial and drives the monitor outputs
// hits arrive one cycle after pos, so sync and dial are delayed to match
// outputs are registered, two cycles after the raster counter state
`include "clock_face_settings.svh"

module face_composer (
  input  logic                       vgaclk,
  input  logic                       rst_n,
  input  clock_face_pkg::pixel_pos_t pos,
  input  clock_face_pkg::sync_t      sync,
  input  logic [2:0]                 hits,    // indexed by hand_id_t
  output logic                       hsync,
  output logic                       vsync,
  output logic                       sync_b,
  output clock_face_pkg::rgb_t       rgb
);
  import clock_face_pkg::*;

  logic signed [11:0] dx, dy;   // offset from dial centre
  logic               in_dial;
  sync_t              sync_q;   // aligned with hits
  logic               dial_q;
  rgb_t               pix;

  // strictly inside the circle
  always_comb
  begin
    dx      = 12'($signed({2'b00, pos.x}) - `DIAL_X);
    dy      = 12'($signed({2'b00, pos.y}) - `DIAL_Y);
    in_dial = (dx * dx + dy * dy) < (`DIAL_R * `DIAL_R);
  end

  // stage 1, wait for the hand pipeline
  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      sync_q <= '{hsync: 1'b1, vsync: 1'b1, visible: 1'b0};
      dial_q <= 1'b0;
    end
    else
    begin
      sync_q <= sync;
      dial_q <= in_dial;
    end
  end

  // second over minute over hour over face
  always_comb
  begin
    if (hits[HAND_SECOND])
      pix = `SECOND_RGB;
    else if (hits[HAND_MINUTE])
      pix = `MINUTE_RGB;
    else if (hits[HAND_HOUR])
      pix = `HOUR_RGB;
    else if (dial_q)
      pix = `FACE_RGB;
    else
      pix = '0;     // background
  end

  // stage 2, output registers
  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hsync  <= 1'b1;
      vsync  <= 1'b1;
      sync_b <= 1'b1;
      rgb    <= '0;
    end
    else
    begin
      hsync  <= sync_q.hsync;
      vsync  <= sync_q.vsync;
      sync_b <= sync_q.hsync | sync_q.vsync;    // low only while both syncs low
      rgb    <= sync_q.visible ? pix : '0;      // blanking
    end
  end

endmodule

// ==== verilog/hand_angle.sv ====
// turns the time input into one 6 degree tick per hand
// time is sampled once per frame at the falling edge of vsync, so no tearing
// now must be stable around that edge, hour is expected in 0..23
module hand_angle (
  input  logic                       vgaclk,
  input  logic                       rst_n,
  input  clock_face_pkg::clock_time_t now,
  input  clock_face_pkg::sync_t       sync,
  output clock_face_pkg::tick_t       ticks [3]
);
  import clock_face_pkg::*;

  logic       vsync_q;      // vsync one cycle back
  logic       frame_start;  // first cycle of vsync low
  logic [3:0] hour12;
  tick_t      hour_tick;

  assign frame_start = vsync_q && !sync.vsync;

  // hour hand creeps forward one tick every 12 minutes
  always_comb
  begin
    hour12    = 4'(now.hour % 5'd12);
    hour_tick = tick_t'(hour12) * 6'd5 + tick_t'(now.minute / 6'd12);  // max 59
  end

  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
      vsync_q <= 1'b1;  // idle high so reset is not an edge
    else
      vsync_q <= sync.vsync;
  end

  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      ticks[HAND_SECOND] <= '0;
      ticks[HAND_MINUTE] <= '0;
      ticks[HAND_HOUR]   <= '0;
    end
    else if (frame_start)
    begin
      ticks[HAND_SECOND] <= now.second;
      ticks[HAND_MINUTE] <= now.minute;
      ticks[HAND_HOUR]   <= hour_tick;
    end
  end

endmodule

// ==== verilog/hand_raster.sv ====
// one clock hand, a rectangle rotated about the dial centre
// tick 0 is 12 o'clock, angle from 3 o'clock is 90 minus 6*tick degrees
// one register stage, hit belongs to the pos of the previous cycle
// ticks 60..63 give undefined angles
`include "clock_face_settings.svh"

module hand_raster #(
  parameter clock_face_pkg::hand_geom_t geom = '0
) (
  input  logic                       vgaclk,
  input  logic                       rst_n,
  input  clock_face_pkg::pixel_pos_t pos,
  input  clock_face_pkg::tick_t      tick,
  output logic                       hit
);
  import clock_face_pkg::*;

  // rectangle bounds, edges included
  localparam logic signed [12:0] X_LO = 13'(geom.x);
  localparam logic signed [12:0] X_HI = 13'(geom.x) + 13'(geom.len);
  localparam logic signed [12:0] Y_LO = 13'(geom.y);
  localparam logic signed [12:0] Y_HI = 13'(geom.y) + 13'(geom.wid);

  // sin of k*6 degrees for the first quadrant
  function automatic trig_t quarter_sin(input logic [3:0] k);
    int v;
    case (k)
      4'd0:  v = 0;
      4'd1:  v = 6850;
      4'd2:  v = 13626;
      4'd3:  v = 20252;
      4'd4:  v = 26656;
      4'd5:  v = 32768;   // 30 deg
      4'd6:  v = 38521;
      4'd7:  v = 43852;
      4'd8:  v = 48702;
      4'd9:  v = 53020;
      4'd10: v = 56756;
      4'd11: v = 59870;
      4'd12: v = 62329;
      4'd13: v = 64104;
      4'd14: v = 65177;
      default: v = 65536; // 90 deg
    endcase
    return trig_t'(v);
  endfunction

  // full circle folded onto the quarter table
  function automatic trig_t sin6(input tick_t t);
    tick_t k;
    logic  neg;
    neg = (t > 6'd30);  // lower half is negative
    if (t <= 6'd15)
      k = t;
    else if (t <= 6'd30)
      k = 6'd30 - t;
    else if (t <= 6'd45)
      k = t - 6'd30;
    else
      k = 6'd60 - t;
    return neg ? -quarter_sin(k[3:0]) : quarter_sin(k[3:0]);
  endfunction

  tick_t                t_cos;       // tick shifted a quarter turn
  trig_t                cos_v;       // cos of hand angle
  trig_t                sin_v;       // sin of hand angle
  logic signed [11:0]   dx, dy;      // offset from dial centre
  logic signed [30:0]   xr, yr;      // rotated, still scaled
  logic signed [12:0]   x0, y0;      // unrotated pixel
  logic                 in_rect;

  always_comb
  begin
    t_cos = (tick >= 6'd45) ? tick - 6'd45 : tick + 6'd15;
    cos_v = sin6(tick);   // cos(90 - a) = sin(a)
    sin_v = sin6(t_cos);  // sin(90 - a) = cos(a)
    dx    = 12'($signed({2'b00, pos.x}) - `DIAL_X);
    dy    = 12'($signed({2'b00, pos.y}) - `DIAL_Y);
    // inverse rotation back onto the unrotated hand
    xr    = dx * cos_v - dy * sin_v;
    yr    = dy * cos_v + dx * sin_v;
    x0    = 13'(xr >>> `TRIG_FRAC) + 13'(`DIAL_X);
    y0    = 13'(yr >>> `TRIG_FRAC) + 13'(`DIAL_Y);
    in_rect = (x0 >= X_LO) && (x0 <= X_HI) && (y0 >= Y_LO) && (y0 <= Y_HI);
  end

  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
      hit <= 1'b0;
    else
      hit <= in_rect;
  end

endmodule

// ==== verilog/vga_timing.sv ====
// raster counters for an 800x525 frame, vcnt steps when hcnt wraps
// pos and sync are decoded from the counter state without a register stage
// pos wraps to large values outside the visible window
`include "clock_face_settings.svh"

module vga_timing (
  input  logic                      vgaclk,
  input  logic                      rst_n,
  output clock_face_pkg::pixel_pos_t pos,
  output clock_face_pkg::sync_t      sync
);
  import clock_face_pkg::*;

  coord_t hcnt;      // 0..799
  coord_t vcnt;      // 0..524
  logic   h_wrap;
  logic   h_vis;
  logic   v_vis;

  assign h_wrap = (hcnt == coord_t'(`H_TOTAL - 1));

  always_ff @(posedge vgaclk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      hcnt <= '0;
      vcnt <= '0;
    end
    else
    begin
      hcnt <= h_wrap ? '0 : hcnt + 1'b1;
      if (h_wrap)  // new line
      begin
        if (vcnt == coord_t'(`V_TOTAL - 1))
          vcnt <= '0;  // new frame
        else
          vcnt <= vcnt + 1'b1;
      end
    end
  end

  // visible windows, end exclusive
  assign h_vis = (hcnt >= coord_t'(`H_VIS_START)) &&
                 (hcnt <  coord_t'(`H_VIS_START + `H_VIS));
  assign v_vis = (vcnt >= coord_t'(`V_VIS_START)) &&
                 (vcnt <  coord_t'(`V_VIS_START + `V_VIS));

  always_comb
  begin
    sync.hsync   = ~((hcnt >= coord_t'(`H_SYNC_START)) && (hcnt < coord_t'(`H_SYNC_END)));
    sync.vsync   = ~((vcnt >= coord_t'(`V_SYNC_START)) && (vcnt < coord_t'(`V_SYNC_END)));
    sync.visible = h_vis && v_vis;
    pos.x        = hcnt - coord_t'(`H_VIS_START);  // modulo 1024
    pos.y        = vcnt - coord_t'(`V_VIS_START);
  end

endmodule
